// ==== mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// data path and address width.
`define NB_DATA  32

// register file address width.
`define NB_REGWR 5

// the data memory holds 256 words, so its word address is 8 bits wide.
`define DMEM_AW  8

`endif

// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        NOR  = 4'd5,
        SLT  = 4'd6,
        SLTU = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11
    } alu_op_e;

    // memory control field laid out as {unsigned, size[1:0], write, read}.
    typedef logic [4:0] mem_ctrl_t;

    localparam int MEM_READ_BIT     = 0;
    localparam int MEM_WRITE_BIT    = 1;
    localparam int MEM_SIZE_LSB     = 2;
    localparam int MEM_SIZE_MSB     = 3;
    localparam int MEM_UNSIGNED_BIT = 4;

    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // writeback control field laid out as {link, mem_to_reg, reg_write}.
    typedef logic [2:0] wb_ctrl_t;

    localparam int WB_REG_WRITE_BIT  = 0;
    localparam int WB_MEM_TO_REG_BIT = 1;
    localparam int WB_LINK_BIT       = 2;

endpackage

// ==== pipe_pkg.sv ====
`include "mips_consts.svh"

package pipe_pkg;

    // operands, results, addresses and the pc.
    typedef logic [`NB_DATA-1:0] data_t;

    // destination register number.
    typedef logic [`NB_REGWR-1:0] reg_addr_t;

    // one write enable per byte lane where lane 0 is the low byte.
    typedef logic [3:0] byte_en_t;

endpackage

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
(
    input  mips_isa_pkg::alu_op_e alu_op_i,
    input  pipe_pkg::data_t       operand_a_i,
    input  pipe_pkg::data_t       operand_b_i,
    output pipe_pkg::data_t       result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // the shift amount comes from the low bits of operand a.
    assign shamt       = operand_a_i[4:0];
    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;

    always_comb
    begin
        case (alu_op_i)
            mips_isa_pkg::ADD:
                result_o = operand_a_i + operand_b_i;
            mips_isa_pkg::SUB:
                result_o = operand_a_i - operand_b_i;
            mips_isa_pkg::AND:
                result_o = operand_a_i & operand_b_i;
            mips_isa_pkg::OR:
                result_o = operand_a_i | operand_b_i;
            mips_isa_pkg::XOR:
                result_o = operand_a_i ^ operand_b_i;
            mips_isa_pkg::NOR:
                result_o = ~(operand_a_i | operand_b_i);
            mips_isa_pkg::SLT:
                result_o = pipe_pkg::data_t'(lt_signed);
            mips_isa_pkg::SLTU:
                result_o = pipe_pkg::data_t'(lt_unsigned);
            mips_isa_pkg::SLL:
                result_o = operand_b_i << shamt;
            mips_isa_pkg::SRL:
                result_o = operand_b_i >> shamt;
            mips_isa_pkg::SRA:
                result_o = $signed(operand_b_i) >>> shamt;
            mips_isa_pkg::LUI:
                result_o = {operand_b_i[15:0], 16'h0000};
            default:
                result_o = '0;
        endcase
    end

endmodule

// ==== store_formatter.sv ====
`timescale 1ns/1ps

module store_formatter
(
    input  pipe_pkg::data_t    store_data_i,
    input  logic [1:0]         size_i,
    input  logic [1:0]         offset_i,
    output pipe_pkg::data_t    lane_data_o,
    output pipe_pkg::byte_en_t byte_en_o
);

    // the data is replicated so that every lane carries it, and the enables pick the lane.
    always_comb
    begin
        case (size_i)
            mips_isa_pkg::SIZE_BYTE:
            begin
                lane_data_o = {4{store_data_i[7:0]}};
                byte_en_o   = 4'b0001 << offset_i;
            end
            mips_isa_pkg::SIZE_HALF:
            begin
                lane_data_o = {2{store_data_i[15:0]}};
                byte_en_o   = offset_i[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                lane_data_o = store_data_i;
                byte_en_o   = 4'b1111;
            end
        endcase
    end

    always_comb
    begin
        if (size_i == mips_isa_pkg::SIZE_HALF && !$isunknown(offset_i))
            assert #0 (offset_i[0] == 1'b0)
                else $error("odd offset %0d on a halfword access", offset_i);
        if (size_i == mips_isa_pkg::SIZE_WORD && !$isunknown(offset_i))
            assert #0 (offset_i == 2'b00)
                else $error("nonzero offset %0d on a word access", offset_i);
    end

endmodule

// ==== ex_mem_stage.sv ====
`timescale 1ns/1ps

module ex_mem_stage
(
    input  logic                   clock,
    input  logic                   reset_i,
    input  logic                   en_pipeline_i,
    input  pipe_pkg::data_t        alu_result_i,
    input  pipe_pkg::data_t        lane_data_i,
    input  pipe_pkg::byte_en_t     byte_en_i,
    input  pipe_pkg::reg_addr_t    write_reg_i,
    input  pipe_pkg::data_t        pc_i,
    input  mips_isa_pkg::mem_ctrl_t mem_ctrl_i,
    input  mips_isa_pkg::wb_ctrl_t wb_ctrl_i,
    input  logic                   halt_i,
    output pipe_pkg::data_t        alu_result_o,
    output pipe_pkg::data_t        lane_data_o,
    output pipe_pkg::byte_en_t     byte_en_o,
    output pipe_pkg::reg_addr_t    write_reg_o,
    output pipe_pkg::data_t        pc_o,
    output mips_isa_pkg::mem_ctrl_t mem_ctrl_o,
    output mips_isa_pkg::wb_ctrl_t wb_ctrl_o,
    output logic                   halt_o
);

    // everything holds while the pipeline is stalled.
    always_ff @(posedge clock)
    begin
        if (reset_i)
        begin
            alu_result_o <= '0;
            lane_data_o  <= '0;
            byte_en_o    <= '0;
            write_reg_o  <= '0;
            pc_o         <= '0;
            mem_ctrl_o   <= '0;
            wb_ctrl_o    <= '0;
            halt_o       <= 1'b0;
        end
        else if (en_pipeline_i)
        begin
            alu_result_o <= alu_result_i;
            lane_data_o  <= lane_data_i;
            byte_en_o    <= byte_en_i;
            write_reg_o  <= write_reg_i;
            pc_o         <= pc_i;
            mem_ctrl_o   <= mem_ctrl_i;
            wb_ctrl_o    <= wb_ctrl_i;
            halt_o       <= halt_i;
        end
    end

    // an operation in the memory stage either loads or stores, never both.
    assert property (@(posedge clock) disable iff (reset_i)
        !(mem_ctrl_o[mips_isa_pkg::MEM_READ_BIT] && mem_ctrl_o[mips_isa_pkg::MEM_WRITE_BIT]))
        else $error("memory stage holds a load and a store at once");

endmodule

// ==== data_mem_stage.sv ====
`timescale 1ns/1ps

`include "mips_consts.svh"

module data_mem_stage
(
    input  logic                    clock,
    input  logic                    reset_i,
    input  logic                    en_pipeline_i,
    input  pipe_pkg::data_t         addr_i,
    input  pipe_pkg::data_t         lane_data_i,
    input  pipe_pkg::byte_en_t      byte_en_i,
    input  pipe_pkg::data_t         pc_i,
    input  pipe_pkg::reg_addr_t     write_reg_i,
    input  mips_isa_pkg::mem_ctrl_t mem_ctrl_i,
    input  mips_isa_pkg::wb_ctrl_t  wb_ctrl_i,
    input  logic                    halt_i,
    output pipe_pkg::data_t         wb_data_o,
    output pipe_pkg::reg_addr_t     wb_reg_o,
    output logic                    wb_write_o,
    output logic                    halt_o
);

    pipe_pkg::data_t    mem [0:(1 << `DMEM_AW)-1];
    logic [`DMEM_AW-1:0] word_idx;
    logic [1:0]         offset;
    logic [1:0]         size;
    logic               load_unsigned;
    pipe_pkg::data_t    rd_word;
    logic [7:0]         rd_byte;
    logic [15:0]        rd_half;
    pipe_pkg::data_t    load_data;
    pipe_pkg::data_t    wb_data;

    assign word_idx      = addr_i[`DMEM_AW+1:2];
    assign offset        = addr_i[1:0];
    assign size          = mem_ctrl_i[mips_isa_pkg::MEM_SIZE_MSB:mips_isa_pkg::MEM_SIZE_LSB];
    assign load_unsigned = mem_ctrl_i[mips_isa_pkg::MEM_UNSIGNED_BIT];

    // a store commits on the same enabled edge that moves it into writeback.
    always_ff @(posedge clock)
    begin
        if (en_pipeline_i && mem_ctrl_i[mips_isa_pkg::MEM_WRITE_BIT])
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byte_en_i[i])
                    mem[word_idx][i*8 +: 8] <= lane_data_i[i*8 +: 8];
            end
        end
    end

    assign rd_word = mem[word_idx];
    assign rd_byte = rd_word[offset*8 +: 8];
    assign rd_half = offset[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb
    begin
        case (size)
            mips_isa_pkg::SIZE_BYTE:
                load_data = load_unsigned ? {24'd0, rd_byte} : {{24{rd_byte[7]}}, rd_byte};
            mips_isa_pkg::SIZE_HALF:
                load_data = load_unsigned ? {16'd0, rd_half} : {{16{rd_half[15]}}, rd_half};
            default:
                load_data = rd_word;
        endcase
    end

    // link wins over a load, and the alu result is the fallback.
    assign wb_data = wb_ctrl_i[mips_isa_pkg::WB_LINK_BIT]       ? pc_i + 32'd4 :
                     wb_ctrl_i[mips_isa_pkg::WB_MEM_TO_REG_BIT] ? load_data    :
                                                                  addr_i;

    always_ff @(posedge clock)
    begin
        if (reset_i)
        begin
            wb_data_o  <= '0;
            wb_reg_o   <= '0;
            wb_write_o <= 1'b0;
            halt_o     <= 1'b0;
        end
        else if (en_pipeline_i)
        begin
            wb_data_o  <= wb_data;
            wb_reg_o   <= write_reg_i;
            wb_write_o <= wb_ctrl_i[mips_isa_pkg::WB_REG_WRITE_BIT];
            halt_o     <= halt_i;
        end
    end

    // the register file write strobe must stay known once the pipe is out of reset.
    assert property (@(posedge clock) disable iff (reset_i) !$isunknown(wb_write_o))
        else $error("wb_write_o is unknown");

endmodule

// ==== ex_mem_subsystem.sv ====
`timescale 1ns/1ps

module ex_mem_subsystem
(
    input  logic                    clock,
    input  logic                    reset_i,
    input  logic                    en_pipeline_i,
    input  mips_isa_pkg::alu_op_e   alu_op_i,
    input  pipe_pkg::data_t         operand_a_i,
    input  pipe_pkg::data_t         operand_b_i,
    input  pipe_pkg::data_t         store_data_i,
    input  pipe_pkg::reg_addr_t     write_reg_i,
    input  pipe_pkg::data_t         pc_i,
    input  mips_isa_pkg::mem_ctrl_t mem_ctrl_i,
    input  mips_isa_pkg::wb_ctrl_t  wb_ctrl_i,
    input  logic                    halt_i,
    output pipe_pkg::data_t         wb_data_o,
    output pipe_pkg::reg_addr_t     wb_reg_o,
    output logic                    wb_write_o,
    output logic                    halt_o
);

    pipe_pkg::data_t         alu_result;
    pipe_pkg::data_t         lane_data;
    pipe_pkg::byte_en_t      byte_en;

    pipe_pkg::data_t         mem_addr;
    pipe_pkg::data_t         mem_lane_data;
    pipe_pkg::byte_en_t      mem_byte_en;
    pipe_pkg::reg_addr_t     mem_write_reg;
    pipe_pkg::data_t         mem_pc;
    mips_isa_pkg::mem_ctrl_t mem_mem_ctrl;
    mips_isa_pkg::wb_ctrl_t  mem_wb_ctrl;
    logic                    mem_halt;

    alu_unit alu_i
    (
        .alu_op_i    (alu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (alu_result)
    );

    // the formatter only needs the byte offset of the computed address.
    store_formatter store_formatter_i
    (
        .store_data_i (store_data_i),
        .size_i       (mem_ctrl_i[mips_isa_pkg::MEM_SIZE_MSB:mips_isa_pkg::MEM_SIZE_LSB]),
        .offset_i     (alu_result[1:0]),
        .lane_data_o  (lane_data),
        .byte_en_o    (byte_en)
    );

    ex_mem_stage ex_mem_stage_i
    (
        .clock         (clock),
        .reset_i       (reset_i),
        .en_pipeline_i (en_pipeline_i),
        .alu_result_i  (alu_result),
        .lane_data_i   (lane_data),
        .byte_en_i     (byte_en),
        .write_reg_i   (write_reg_i),
        .pc_i          (pc_i),
        .mem_ctrl_i    (mem_ctrl_i),
        .wb_ctrl_i     (wb_ctrl_i),
        .halt_i        (halt_i),
        .alu_result_o  (mem_addr),
        .lane_data_o   (mem_lane_data),
        .byte_en_o     (mem_byte_en),
        .write_reg_o   (mem_write_reg),
        .pc_o          (mem_pc),
        .mem_ctrl_o    (mem_mem_ctrl),
        .wb_ctrl_o     (mem_wb_ctrl),
        .halt_o        (mem_halt)
    );

    data_mem_stage data_mem_stage_i
    (
        .clock         (clock),
        .reset_i       (reset_i),
        .en_pipeline_i (en_pipeline_i),
        .addr_i        (mem_addr),
        .lane_data_i   (mem_lane_data),
        .byte_en_i     (mem_byte_en),
        .pc_i          (mem_pc),
        .write_reg_i   (mem_write_reg),
        .mem_ctrl_i    (mem_mem_ctrl),
        .wb_ctrl_i     (mem_wb_ctrl),
        .halt_i        (mem_halt),
        .wb_data_o     (wb_data_o),
        .wb_reg_o      (wb_reg_o),
        .wb_write_o    (wb_write_o),
        .halt_o        (halt_o)
    );

endmodule

// ==== tb_ex_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_ex_mem_subsystem;

    localparam int MAX_OPS = 64;

    logic                    clock;
    logic                    reset_i;
    logic                    en_pipeline_i;
    mips_isa_pkg::alu_op_e   alu_op_i;
    pipe_pkg::data_t         operand_a_i;
    pipe_pkg::data_t         operand_b_i;
    pipe_pkg::data_t         store_data_i;
    pipe_pkg::reg_addr_t     write_reg_i;
    pipe_pkg::data_t         pc_i;
    mips_isa_pkg::mem_ctrl_t mem_ctrl_i;
    mips_isa_pkg::wb_ctrl_t  wb_ctrl_i;
    logic                    halt_i;
    pipe_pkg::data_t         wb_data_o;
    pipe_pkg::reg_addr_t     wb_reg_o;
    logic                    wb_write_o;
    logic                    halt_o;

    // one entry per stim line with the columns in file order.
    logic [31:0] op_tab   [MAX_OPS];
    logic [31:0] a_tab    [MAX_OPS];
    logic [31:0] b_tab    [MAX_OPS];
    logic [31:0] sd_tab   [MAX_OPS];
    logic [31:0] wr_tab   [MAX_OPS];
    logic [31:0] pc_tab   [MAX_OPS];
    logic [31:0] mc_tab   [MAX_OPS];
    logic [31:0] wbc_tab  [MAX_OPS];
    logic [31:0] halt_tab [MAX_OPS];
    logic [31:0] exp_tab  [MAX_OPS];

    int          num_ops;
    int          error_count;
    int          checked;
    logic        stim_loaded;
    logic [31:0] rng;

    // index of the operation held in EX/MEM where -1 marks a bubble.
    int          in_flight [$];

    ex_mem_subsystem dut_i
    (
        .clock         (clock),
        .reset_i       (reset_i),
        .en_pipeline_i (en_pipeline_i),
        .alu_op_i      (alu_op_i),
        .operand_a_i   (operand_a_i),
        .operand_b_i   (operand_b_i),
        .store_data_i  (store_data_i),
        .write_reg_i   (write_reg_i),
        .pc_i          (pc_i),
        .mem_ctrl_i    (mem_ctrl_i),
        .wb_ctrl_i     (wb_ctrl_i),
        .halt_i        (halt_i),
        .wb_data_o     (wb_data_o),
        .wb_reg_o      (wb_reg_o),
        .wb_write_o    (wb_write_o),
        .halt_o        (halt_o)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #4 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0t %s got 0x%08h expected 0x%08h", $time, name, actual, expected);
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [10];
        fd = $fopen("ex_mem_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open ex_mem_stim.txt for reading");
            return;
        end
        while (!$feof(fd) && num_ops < MAX_OPS)
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7], f[8], f[9]);
                if (n == 10)
                begin
                    op_tab[num_ops]   = f[0];
                    a_tab[num_ops]    = f[1];
                    b_tab[num_ops]    = f[2];
                    sd_tab[num_ops]   = f[3];
                    wr_tab[num_ops]   = f[4];
                    pc_tab[num_ops]   = f[5];
                    mc_tab[num_ops]   = f[6];
                    wbc_tab[num_ops]  = f[7];
                    halt_tab[num_ops] = f[8];
                    exp_tab[num_ops]  = f[9];
                    num_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    // past the last line the pipe is fed with bubbles.
    task automatic drive_op(input int idx);
        if (idx < num_ops)
        begin
            alu_op_i     <= mips_isa_pkg::alu_op_e'(op_tab[idx][3:0]);
            operand_a_i  <= a_tab[idx];
            operand_b_i  <= b_tab[idx];
            store_data_i <= sd_tab[idx];
            write_reg_i  <= wr_tab[idx][4:0];
            pc_i         <= pc_tab[idx];
            mem_ctrl_i   <= mc_tab[idx][4:0];
            wb_ctrl_i    <= wbc_tab[idx][2:0];
            halt_i       <= halt_tab[idx][0];
        end
        else
        begin
            alu_op_i     <= mips_isa_pkg::ADD;
            operand_a_i  <= '0;
            operand_b_i  <= '0;
            store_data_i <= '0;
            write_reg_i  <= '0;
            pc_i         <= '0;
            mem_ctrl_i   <= '0;
            wb_ctrl_i    <= '0;
            halt_i       <= 1'b0;
        end
    endtask

    task automatic check_output(input int idx);
        if (idx < 0)
        begin
            compare_value("wb_write_o", wb_write_o, 32'd0);
            compare_value("halt_o", halt_o, 32'd0);
        end
        else
        begin
            compare_value("wb_data_o", wb_data_o, exp_tab[idx]);
            compare_value("wb_reg_o", wb_reg_o, wr_tab[idx]);
            compare_value("wb_write_o", wb_write_o, wbc_tab[idx][0]);
            compare_value("halt_o", halt_o, halt_tab[idx][0]);
        end
    endtask

    initial
    begin
        wait (stim_loaded);
        #((num_ops * 4 + 50) * 8);
        $display("run timed out before the halt operation reached the outputs");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic stepped;
        logic finished;
        int   check_idx;
        int   op_idx;
        reset_i       = 1'b1;
        en_pipeline_i = 1'b0;
        alu_op_i      = mips_isa_pkg::ADD;
        operand_a_i   = '0;
        operand_b_i   = '0;
        store_data_i  = '0;
        write_reg_i   = '0;
        pc_i          = '0;
        mem_ctrl_i    = '0;
        wb_ctrl_i     = '0;
        halt_i        = 1'b0;
        num_ops       = 0;
        error_count   = 0;
        checked       = 0;
        stim_loaded   = 1'b0;
        rng           = 32'hf077;
        load_stim();
        if (num_ops == 0)
        begin
            $display("no operations could be read from ex_mem_stim.txt");
            error_count++;
        end
        else
        begin
            stim_loaded = 1'b1;
            in_flight.push_back(-1);
            op_idx    = 0;
            check_idx = -1;
            finished  = 1'b0;
            repeat (10) @(posedge clock);
            reset_i       <= 1'b0;
            en_pipeline_i <= 1'b1;
            drive_op(0);
            @(negedge clock);
            compare_value("wb_write_o", wb_write_o, 32'd0);
            compare_value("halt_o", halt_o, 32'd0);
            while (!finished)
            begin
                @(posedge clock);
                stepped = en_pipeline_i;
                rng = xorshift32(rng);
                en_pipeline_i <= (rng[1:0] != 2'b00);
                // only an enabled edge takes the presented operation in.
                if (stepped)
                begin
                    check_idx = in_flight.pop_front();
                    if (op_idx < num_ops)
                    begin
                        in_flight.push_back(op_idx);
                        op_idx++;
                    end
                    else
                        in_flight.push_back(-1);
                    drive_op(op_idx);
                end
                // a stalled edge must leave the previous result at the outputs.
                @(negedge clock);
                check_output(check_idx);
                if (stepped && check_idx >= 0)
                    checked++;
                finished = (checked == num_ops) ||
                           (check_idx >= 0 && halt_tab[check_idx][0]);
            end
        end
        $display("checked %0d of %0d operations, %0d errors", checked, num_ops, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== ex_mem_stim.txt ====
# each line holds alu_op, operand_a, operand_b, store_data, write_reg, pc,
# mem_ctrl, wb_ctrl, halt and the expected wb_data, all in hex.
0 00000005 00000007 00000000 01 00400000 00 1 0 0000000c
1 00000003 00000005 00000000 02 00400004 00 1 0 fffffffe
2 f0f0ff00 0ff00f0f 00000000 03 00400008 00 1 0 00f00f00
3 12340000 00005678 00000000 04 0040000c 00 1 0 12345678
4 ffff0000 0f0f0f0f 00000000 05 00400010 00 1 0 f0f00f0f
5 0000ff00 00ff0000 00000000 06 00400014 00 1 0 ff0000ff
6 ffffffff 00000001 00000000 07 00400018 00 1 0 00000001
7 ffffffff 00000001 00000000 08 0040001c 00 1 0 00000000
8 00000004 0000000f 00000000 09 00400020 00 1 0 000000f0
9 00000008 80000000 00000000 0a 00400024 00 1 0 00800000
a 00000008 80000000 00000000 0b 00400028 00 1 0 ff800000
b 00000000 0000abcd 00000000 0c 0040002c 00 1 0 abcd0000
0 00000100 00000000 11223344 00 00400030 0a 0 0 00000100
0 00000100 00000001 000000aa 00 00400034 02 0 0 00000101
0 00000100 00000002 0000beef 00 00400038 06 0 0 00000102
0 00000100 00000000 00000000 0d 0040003c 09 3 0 beefaa44
0 00000100 00000000 00000000 0e 00400040 01 3 0 00000044
0 00000100 00000001 00000000 0f 00400044 01 3 0 ffffffaa
0 00000100 00000001 00000000 10 00400048 11 3 0 000000aa
0 00000100 00000003 00000000 11 0040004c 01 3 0 ffffffbe
0 00000100 00000002 00000000 12 00400050 11 3 0 000000ef
0 00000100 00000000 00000000 13 00400054 05 3 0 ffffaa44
0 00000100 00000002 00000000 14 00400058 15 3 0 0000beef
0 00000000 00000000 00000000 1f 0040005c 00 5 0 00400060
0 00000000 00000000 00000000 00 00400060 00 0 1 00000000

// ==== sim.f ====
+incdir+.
mips_isa_pkg.sv
pipe_pkg.sv
alu_unit.sv
store_formatter.sv
ex_mem_stage.sv
data_mem_stage.sv
ex_mem_subsystem.sv
tb_ex_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: ex_mem_subsystem

sources:
  - include_dirs:
      - .
    files:
      - mips_isa_pkg.sv
      - pipe_pkg.sv
      - alu_unit.sv
      - store_formatter.sv
      - ex_mem_stage.sv
      - data_mem_stage.sv
      - ex_mem_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ex_mem_subsystem.sv
